//--- palu_top.f
+incdir+.
hdl/palu_pkg.sv
hdl/palu_decode.sv
hdl/palu_adder.sv
hdl/palu_shifter.sv
hdl/palu_multiplier.sv
hdl/palu_bitwise.sv
hdl/palu_result.sv
hdl/palu_top.sv
tb/palu_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := palu_tb
FILELIST  := palu_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides pass or fail, whatever the binary's exit status
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/palu_tb.sv
// --------------------
// Packed ALU testbench
// Directed tests against a lane-wise reference model
// --------------------
`timescale 1ns/100ps
`include "palu_macros.svh"

module palu_tb;
    import palu_pkg::*;

    localparam int MAX_WAIT    = 40;   // Cycles, above the worst 32-bit multiply
    localparam int MAX_OPS     = 256;  // Upper bound on issued instructions
    localparam int WATCHDOG_NS = (5 + MAX_OPS * (MAX_WAIT + 4)) * 10;

    logic    g_clk = 1'b0;
    logic    rst_i;
    logic    valid_i;
    word_t   gpr_rs1_i;
    word_t   rs1_i;
    word_t   rs2_i;
    word_t   rs3_i;
    word_t   imm_i;
    pw_t     pw_i;
    iclass_t iclass_i;
    sclass_t sclass_i;
    logic    done_o;
    ben_t    rd_ben_o;
    word_t   rd_wdata_o;

    always #5 g_clk = ~g_clk;

    palu_top DUT (.*);

    // --------------------
    // Reference model
    function automatic int lane_bits(pw_t pw);
        case (pw)
            `PALU_PW_16: return 16;
            `PALU_PW_8:  return 8;
            `PALU_PW_4:  return 4;
            `PALU_PW_2:  return 2;
            default:     return 32;
        endcase
    endfunction

    // Zero cycles, or load plus one step per lane bit before done
    function automatic int ref_latency(iclass_t ic, sclass_t sc, pw_t pw);
        if (ic == `PALU_CLASS_ARITH && sc >= `PALU_SC_PMUL_L && sc <= `PALU_SC_PCLMUL_H)
            return lane_bits(pw) + 1;
        return 0;
    endfunction

    function automatic word_t ref_add(word_t a, word_t b, pw_t pw, bit sub);
        int          w;
        logic [63:0] m;
        logic [63:0] la;
        logic [63:0] lb;
        logic [63:0] r;
        word_t       res;
        w   = lane_bits(pw);
        m   = (64'd1 << w) - 64'd1;
        res = '0;
        for (int l = 0; l < 32 / w; l++) begin
            la  = (64'(a) >> (l * w)) & m;
            lb  = (64'(b) >> (l * w)) & m;
            r   = sub ? la - lb : la + lb;  // Wraps within the lane
            res = res | word_t'((r & m) << (l * w));
        end
        return res;
    endfunction

    function automatic word_t ref_shift(word_t a, int amt, pw_t pw, bit left, bit rot);
        int          w;
        int          s;
        logic [63:0] m;
        logic [63:0] la;
        logic [63:0] r;
        word_t       res;
        w   = lane_bits(pw);
        s   = amt % w;
        m   = (64'd1 << w) - 64'd1;
        res = '0;
        for (int l = 0; l < 32 / w; l++) begin
            la = (64'(a) >> (l * w)) & m;
            if (rot)
                r = ((la >> s) | (la << (w - s))) & m;  // Rotate right
            else if (left)
                r = (la << s) & m;
            else
                r = la >> s;
            res = res | word_t'(r << (l * w));
        end
        return res;
    endfunction

    function automatic word_t ref_mul(word_t a, word_t b, pw_t pw, bit high, bit clmul);
        int          w;
        logic [63:0] m;
        logic [63:0] la;
        logic [63:0] lb;
        logic [63:0] p;
        word_t       res;
        w   = lane_bits(pw);
        m   = (64'd1 << w) - 64'd1;
        res = '0;
        for (int l = 0; l < 32 / w; l++) begin
            la = (64'(a) >> (l * w)) & m;
            lb = (64'(b) >> (l * w)) & m;
            p  = '0;
            for (int k = 0; k < w; k++) begin
                if (lb[k]) p = clmul ? p ^ (la << k) : p + (la << k);
            end
            p   = high ? (p >> w) & m : p & m;
            res = res | word_t'(p << (l * w));
        end
        return res;
    endfunction

    function automatic word_t ref_bitwise(sclass_t sc, word_t imm, word_t a, word_t b,
                                          word_t c);
        int          start;
        int          len;
        int          ramt;
        logic [63:0] mask;
        word_t       rot;
        word_t       res;
        start = 2 * imm[7:4];
        len   = 2 * imm[3:0];
        mask  = (64'd1 << len) - 64'd1;
        ramt  = imm[3:0] + ((sc == `PALU_SC_MIX_H) ? 16 : 0);
        rot   = word_t'((64'(a) >> ramt) | (64'(a) << (32 - ramt)));
        res   = '0;
        case (sc)
            `PALU_SC_BOP: begin
                for (int i = 0; i < 32; i++) res[i] = imm[{a[i], b[i]}];
            end
            `PALU_SC_EXT:    res = word_t'((64'(a) >> start) & mask);
            `PALU_SC_INS:    res = word_t'(((64'(a) & mask) << start) |
                                           (64'(c) & ~(mask << start)));
            `PALU_SC_MIX_L,
            `PALU_SC_MIX_H:  res = (b & rot) | (~b & c);
            `PALU_SC_LD_LIU: res = {c[31:16], imm[15:0]};
            `PALU_SC_LD_HIU: res = {imm[15:0], c[15:0]};
            default:         res = '0;
        endcase
        return res;
    endfunction

    // Write rule for the move class
    function automatic ben_t ref_move_ben(sclass_t sc, word_t b);
        case (sc)
            `PALU_SC_CMOV_T: return (b == '0) ? 4'hf : 4'h0;
            `PALU_SC_CMOV_F: return (b != '0) ? 4'hf : 4'h0;
            default:         return 4'hf;
        endcase
    endfunction

    // --------------------
    // Checking and driving
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            abort_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic exec_op(input string name, input iclass_t ic, input sclass_t sc,
                           input pw_t pw, input word_t imm, input word_t gpr, input word_t a,
                           input word_t b, input word_t c, input word_t exp_word,
                           input ben_t exp_ben);
        int    waited;
        word_t got_word;
        ben_t  got_ben;
        @(posedge g_clk);
        valid_i   <= 1'b1;
        iclass_i  <= ic;
        sclass_i  <= sc;
        pw_i      <= pw;
        imm_i     <= imm;
        gpr_rs1_i <= gpr;
        rs1_i     <= a;
        rs2_i     <= b;
        rs3_i     <= c;
        waited = 0;
        @(negedge g_clk);
        while (!done_o) begin
            waited++;
            if (waited > MAX_WAIT) begin
                abort_run($sformatf("%s: done never came within %0d cycles", name, MAX_WAIT));
            end
            @(negedge g_clk);
        end
        got_word = rd_wdata_o;
        got_ben  = rd_ben_o;
        @(posedge g_clk);
        valid_i <= 1'b0;  // Dropped in the cycle after done
        check_value({name, " latency"}, 32'(ref_latency(ic, sc, pw)), 32'(waited));
        check_value({name, " ben"}, 32'(exp_ben), 32'(got_ben));
        check_value(name, exp_word, got_word);
    endtask

    // --------------------
    // Directed tests
    task automatic test_idle_and_unknown();
        @(posedge g_clk);
        iclass_i <= `PALU_CLASS_ARITH;  // A real add, held off by valid low
        sclass_i <= `PALU_SC_PADD;
        repeat (3) begin
            @(negedge g_clk);
            check_value("idle done", 32'd0, 32'(done_o));
            check_value("idle ben", 32'd0, 32'(rd_ben_o));
        end
        @(posedge g_clk);
        valid_i  <= 1'b1;
        iclass_i <= 4'd7;  // Twiddle class, not built
        sclass_i <= 5'd0;
        repeat (3) begin
            @(negedge g_clk);
            check_value("unknown class ben", 32'd0, 32'(rd_ben_o));
            check_value("unknown class done", 32'd0, 32'(done_o));
        end
        @(posedge g_clk);
        valid_i <= 1'b0;
    endtask

    task automatic test_add_sub();
        word_t a;
        word_t b;
        pw_t   pw;
        for (int p = 0; p < 5; p++) begin
            pw = pw_t'(p);
            for (int n = 0; n < 4; n++) begin
                a = $urandom();
                b = $urandom();
                exec_op($sformatf("padd pw%0d", p), `PALU_CLASS_ARITH, `PALU_SC_PADD, pw,
                        '0, '0, a, b, '0, ref_add(a, b, pw, 1'b0), 4'hf);
                exec_op($sformatf("psub pw%0d", p), `PALU_CLASS_ARITH, `PALU_SC_PSUB, pw,
                        '0, '0, a, b, '0, ref_add(a, b, pw, 1'b1), 4'hf);
            end
        end
    endtask

    task automatic test_shifts();
        sclass_t    ops[6] = '{`PALU_SC_PSLL, `PALU_SC_PSRL, `PALU_SC_PROT,
                               `PALU_SC_PSLL_I, `PALU_SC_PSRL_I, `PALU_SC_PROT_I};
        logic [4:0] amts[3];
        word_t      a;
        word_t      b;
        word_t      imm;
        word_t      exp;
        bit         is_imm;
        bit         left;
        bit         rot;
        pw_t        pw;
        int         lw;
        for (int p = 0; p < 5; p++) begin
            pw      = pw_t'(p);
            lw      = lane_bits(pw);
            amts[0] = 5'($urandom() % 32);
            amts[1] = 5'(lw - 1);
            amts[2] = 5'(lw + $urandom() % 4);  // At least the lane width below 32
            foreach (ops[o]) begin
                is_imm = ops[o] >= `PALU_SC_PSLL_I;
                left   = ops[o] == `PALU_SC_PSLL || ops[o] == `PALU_SC_PSLL_I;
                rot    = ops[o] == `PALU_SC_PROT || ops[o] == `PALU_SC_PROT_I;
                foreach (amts[k]) begin
                    a   = $urandom();
                    b   = $urandom();
                    imm = $urandom();
                    if (is_imm) imm[4:0] = amts[k];
                    else        b[4:0]   = amts[k];
                    exp = ref_shift(a, amts[k], pw, left, rot);
                    exec_op($sformatf("shift sc%0d pw%0d amt%0d", ops[o], p, amts[k]),
                            `PALU_CLASS_ARITH, ops[o], pw, imm, '0, a, b, '0, exp, 4'hf);
                end
            end
        end
    endtask

    task automatic test_multiply();
        sclass_t ops[4] = '{`PALU_SC_PMUL_L, `PALU_SC_PMUL_H,
                            `PALU_SC_PCLMUL_L, `PALU_SC_PCLMUL_H};
        word_t   a;
        word_t   b;
        word_t   exp;
        bit      high;
        bit      clmul;
        pw_t     pw;
        for (int p = 0; p < 5; p++) begin
            pw = pw_t'(p);
            foreach (ops[o]) begin
                high  = ops[o] == `PALU_SC_PMUL_H || ops[o] == `PALU_SC_PCLMUL_H;
                clmul = ops[o] >= `PALU_SC_PCLMUL_L;
                repeat (3) begin
                    a   = $urandom();
                    b   = $urandom();
                    exp = ref_mul(a, b, pw, high, clmul);
                    exec_op($sformatf("mul sc%0d pw%0d", ops[o], p), `PALU_CLASS_ARITH,
                            ops[o], pw, '0, '0, a, b, '0, exp, 4'hf);
                end
            end
        end
    endtask

    task automatic test_bitwise();
        sclass_t ops[7] = '{`PALU_SC_BOP, `PALU_SC_EXT, `PALU_SC_INS, `PALU_SC_MIX_L,
                            `PALU_SC_MIX_H, `PALU_SC_LD_LIU, `PALU_SC_LD_HIU};
        word_t   a;
        word_t   b;
        word_t   c;
        word_t   imm;
        foreach (ops[o]) begin
            for (int n = 0; n < 4; n++) begin
                a   = $urandom();
                b   = $urandom();
                c   = $urandom();
                imm = $urandom();  // Low nibble is a random BOP truth table
                exec_op($sformatf("bitwise sc%0d #%0d", ops[o], n), `PALU_CLASS_BITWISE,
                        ops[o], `PALU_PW_32, imm, '0, a, b, c,
                        ref_bitwise(ops[o], imm, a, b, c), 4'hf);
            end
        end
    endtask

    task automatic test_moves();
        word_t a;
        word_t g;
        word_t nz;
        a  = $urandom();
        g  = $urandom();
        nz = $urandom() | 32'h0000_0100;
        exec_op("cmov_t zero", `PALU_CLASS_MOVE, `PALU_SC_CMOV_T, `PALU_PW_32, '0, g, a, '0,
                '0, a, ref_move_ben(`PALU_SC_CMOV_T, '0));
        exec_op("cmov_t nonzero", `PALU_CLASS_MOVE, `PALU_SC_CMOV_T, `PALU_PW_32, '0, g, a, nz,
                '0, a, ref_move_ben(`PALU_SC_CMOV_T, nz));
        exec_op("cmov_f zero", `PALU_CLASS_MOVE, `PALU_SC_CMOV_F, `PALU_PW_32, '0, g, a, '0,
                '0, a, ref_move_ben(`PALU_SC_CMOV_F, '0));
        exec_op("cmov_f nonzero", `PALU_CLASS_MOVE, `PALU_SC_CMOV_F, `PALU_PW_32, '0, g, a, nz,
                '0, a, ref_move_ben(`PALU_SC_CMOV_F, nz));
        exec_op("gpr2xcr", `PALU_CLASS_MOVE, `PALU_SC_GPR2XCR, `PALU_PW_32, '0, g, a, nz,
                '0, g, ref_move_ben(`PALU_SC_GPR2XCR, nz));
    endtask

    // --------------------
    initial begin
        #(WATCHDOG_NS);
        abort_run("Watchdog expired before all tests finished");
    end

    initial begin
        void'($urandom(32'h4acc_49b8));
        rst_i     <= 1'b1;
        valid_i   <= 1'b0;
        gpr_rs1_i <= '0;
        rs1_i     <= '0;
        rs2_i     <= '0;
        rs3_i     <= '0;
        imm_i     <= '0;
        pw_i      <= '0;
        iclass_i  <= '0;
        sclass_i  <= '0;
        repeat (5) @(posedge g_clk);
        rst_i <= 1'b0;
        test_idle_and_unknown();
        test_add_sub();
        test_shifts();
        test_multiply();
        test_bitwise();
        test_moves();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- hdl/palu_top.sv
// --------------------
// Packed ALU top
// Decode, execute units and result select
// --------------------
`timescale 1ns/100ps

module palu_top (
    input  logic              g_clk,
    input  logic              rst_i,
    input  logic              valid_i,    // Held until done
    input  palu_pkg::word_t   gpr_rs1_i,
    input  palu_pkg::word_t   rs1_i,
    input  palu_pkg::word_t   rs2_i,
    input  palu_pkg::word_t   rs3_i,      // Destination CPR value for merges
    input  palu_pkg::word_t   imm_i,
    input  palu_pkg::pw_t     pw_i,
    input  palu_pkg::iclass_t iclass_i,
    input  palu_pkg::sclass_t sclass_i,
    output logic              done_o,
    output palu_pkg::ben_t    rd_ben_o,
    output palu_pkg::word_t   rd_wdata_o
);
    import palu_pkg::*;

    palu_ctrl_t ctrl;
    logic       mul_start;
    logic       mul_busy;
    logic       mul_done;
    logic       cmov_wen;
    word_t      add_res;
    word_t      shift_res;
    word_t      mul_res;
    word_t      bit_res;

    palu_decode u_decode (
        .valid_i     (valid_i),
        .iclass_i    (iclass_i),
        .sclass_i    (sclass_i),
        .pw_i        (pw_i),
        .imm_i       (imm_i),
        .rs2_i       (rs2_i),
        .mul_busy_i  (mul_busy),
        .ctrl_o      (ctrl),
        .mul_start_o (mul_start)
    );

    palu_adder u_adder (
        .a_i   (rs1_i),
        .b_i   (rs2_i),
        .pw_i  (ctrl.pw),
        .sub_i (ctrl.sub),
        .sum_o (add_res)
    );

    palu_shifter u_shifter (
        .a_i      (rs1_i),
        .shamt_i  (ctrl.shamt),
        .pw_i     (ctrl.pw),
        .left_i   (ctrl.shift_left),
        .rotate_i (ctrl.rotate),
        .res_o    (shift_res)
    );

    palu_multiplier u_multiplier (
        .g_clk       (g_clk),
        .rst_i       (rst_i),
        .start_i     (mul_start),
        .a_i         (rs1_i),
        .b_i         (rs2_i),
        .pw_i        (ctrl.pw),
        .high_i      (ctrl.mul_high),
        .carryless_i (ctrl.carryless),
        .busy_o      (mul_busy),
        .done_o      (mul_done),
        .result_o    (mul_res)
    );

    palu_bitwise u_bitwise (
        .ctrl_i     (ctrl),
        .gpr_rs1_i  (gpr_rs1_i),
        .rs1_i      (rs1_i),
        .rs2_i      (rs2_i),
        .rs3_i      (rs3_i),
        .res_o      (bit_res),
        .cmov_wen_o (cmov_wen)
    );

    palu_result u_result (
        .ctrl_i     (ctrl),
        .add_i      (add_res),
        .shift_i    (shift_res),
        .bit_i      (bit_res),
        .mul_i      (mul_res),
        .cmov_wen_i (cmov_wen),
        .mul_done_i (mul_done),
        .done_o     (done_o),
        .rd_ben_o   (rd_ben_o),
        .rd_wdata_o (rd_wdata_o)
    );

endmodule

//--- hdl/palu_result.sv
// --------------------
// Result stage
// Word select, writeback byte enable and done
// --------------------
`timescale 1ns/100ps

module palu_result (
    input  palu_pkg::palu_ctrl_t ctrl_i,
    input  palu_pkg::word_t      add_i,
    input  palu_pkg::word_t      shift_i,
    input  palu_pkg::word_t      bit_i,
    input  palu_pkg::word_t      mul_i,
    input  logic                 cmov_wen_i,
    input  logic                 mul_done_i,
    output logic                 done_o,
    output palu_pkg::ben_t       rd_ben_o,
    output palu_pkg::word_t      rd_wdata_o
);
    import palu_pkg::*;

    always_comb begin
        case (ctrl_i.unit)
            MOVE,
            BITWISE: rd_wdata_o = bit_i;
            ADD:     rd_wdata_o = add_i;
            SHIFT:   rd_wdata_o = shift_i;
            MUL:     rd_wdata_o = mul_i;
            default: rd_wdata_o = '0;
        endcase
    end

    // Only the multiplier takes more than zero cycles
    assign done_o = (ctrl_i.unit == MUL) ? mul_done_i : (ctrl_i.unit != NONE);

    assign rd_ben_o = !done_o              ? '0 :
                      ctrl_i.unit == MOVE  ? {$bits(ben_t){cmov_wen_i}} :
                                             '1;

endmodule

//--- hdl/palu_bitwise.sv
// --------------------
// Bitwise unit
// Moves, BOP, field extract and insert, mix, immediate loads
// --------------------
`timescale 1ns/100ps
`include "palu_macros.svh"

module palu_bitwise (
    input  palu_pkg::palu_ctrl_t ctrl_i,
    input  palu_pkg::word_t      gpr_rs1_i,
    input  palu_pkg::word_t      rs1_i,
    input  palu_pkg::word_t      rs2_i,
    input  palu_pkg::word_t      rs3_i,
    output palu_pkg::word_t      res_o,
    output logic                 cmov_wen_o
);
    import palu_pkg::*;

    logic [4:0]              ei_start;
    logic [4:0]              ei_len;
    logic [4:0]              mix_ramt;
    logic [2*`PALU_XLEN-1:0] mix_dbl;
    word_t                   field_mask;
    word_t                   bop_res;
    word_t                   ext_res;
    word_t                   ins_res;
    word_t                   mix_res;

    // Truth table lookup, rs1 bit is the upper index
    always_comb begin
        for (int i = 0; i < `PALU_XLEN; i++) begin
            bop_res[i] = ctrl_i.imm[{rs1_i[i], rs2_i[i]}];
        end
    end

    assign ei_start   = {ctrl_i.imm[7:4], 1'b0};
    assign ei_len     = {ctrl_i.imm[3:0], 1'b0};
    assign field_mask = ~({`PALU_XLEN{1'b1}} << ei_len);
    assign ext_res    = (rs1_i >> ei_start) & field_mask;
    assign ins_res    = ((rs1_i & field_mask) << ei_start) | (rs3_i & ~(field_mask << ei_start));

    assign mix_ramt = {ctrl_i.bop == MIX_H, ctrl_i.imm[3:0]};
    assign mix_dbl  = {rs1_i, rs1_i} >> mix_ramt;  // Rotate right
    assign mix_res  = (rs2_i & mix_dbl[`PALU_XLEN-1:0]) | (~rs2_i & rs3_i);

    always_comb begin
        case (ctrl_i.bop)
            GPR2XCR: res_o = gpr_rs1_i;
            BOP:     res_o = bop_res;
            EXT:     res_o = ext_res;
            INS:     res_o = ins_res;
            MIX_L,
            MIX_H:   res_o = mix_res;
            LD_LIU:  res_o = {rs3_i[31:16], ctrl_i.imm[15:0]};
            LD_HIU:  res_o = {ctrl_i.imm[15:0], rs3_i[15:0]};
            default: res_o = rs1_i;  // Conditional moves
        endcase
    end

    assign cmov_wen_o = (ctrl_i.bop == GPR2XCR) ||
                        (ctrl_i.bop == CMOV_T && rs2_i == '0) ||
                        (ctrl_i.bop == CMOV_F && rs2_i != '0);

endmodule

//--- hdl/palu_multiplier.sv
// --------------------
// Packed multiplier
// Shift-add over lanes, one multiplier bit per cycle
// Integer or carry-less, low or high half
// --------------------
`timescale 1ns/100ps
`include "palu_macros.svh"

module palu_multiplier (
    input  logic            g_clk,
    input  logic            rst_i,
    input  logic            start_i,
    input  palu_pkg::word_t a_i,
    input  palu_pkg::word_t b_i,
    input  palu_pkg::pw_t   pw_i,
    input  logic            high_i,
    input  logic            carryless_i,
    output logic            busy_o,
    output logic            done_o,
    output palu_pkg::word_t result_o
);
    import palu_pkg::*;

    typedef enum logic [1:0] {IDLE, RUN, DONE} mul_state_t;

    mul_state_t state;
    logic [4:0] cnt;     // Steps left in the lane
    logic [4:0] lmask;
    word_t      acc_hi;  // Upper half of each lane product
    word_t      acc_lo;  // Multiplier bits out, low product bits in
    word_t      nxt_hi;
    word_t      nxt_lo;

    assign lmask = lane_mask(pw_i);

    // --------------------
    // One step: add, then shift each lane pair right
    always_comb begin
        logic       carry;
        logic       pbit;
        logic [4:0] base;
        word_t      psum;
        word_t      top;
        word_t      cout;
        word_t      lo_in;
        carry = 1'b0;
        for (int i = 0; i < `PALU_XLEN; i++) begin
            base = 5'(i) & ~lmask;
            if (5'(i) == base) carry = 1'b0;
            pbit     = acc_lo[base] & a_i[i];  // Lane LSB picks the addend
            psum[i]  = acc_hi[i] ^ pbit ^ carry;
            carry    = !carryless_i & ((acc_hi[i] & pbit) | (carry & (acc_hi[i] ^ pbit)));
            top[i]   = (5'(i) & lmask) == lmask;
            cout[i]  = carry;
            lo_in[i] = psum[base];
        end
        nxt_hi = ((psum >> 1) & ~top) | (cout & top);
        nxt_lo = ((acc_lo >> 1) & ~top) | (lo_in & top);
    end

    // --------------------
    always_ff @(posedge g_clk) begin
        if (rst_i) begin
            state <= IDLE;
            cnt   <= 5'd0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_i) state <= RUN;
                    cnt <= lmask;
                end
                RUN: begin
                    if (cnt == 5'd0) state <= DONE;
                    cnt <= cnt - 5'd1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge g_clk) begin
        if (state == IDLE) begin
            acc_hi <= '0;
            acc_lo <= b_i;
        end else if (state == RUN) begin
            acc_hi <= nxt_hi;
            acc_lo <= nxt_lo;
        end
    end

    assign busy_o   = state != IDLE;
    assign done_o   = state == DONE;
    assign result_o = high_i ? acc_hi : acc_lo;

    // Held valid must never see a second done for the same multiply
    assert property (@(posedge g_clk) disable iff (rst_i) done_o |=> !done_o && !start_i);

endmodule

//--- hdl/palu_shifter.sv
// --------------------
// Packed shifter
// Logical shifts and rotates kept inside each lane
// --------------------
`timescale 1ns/100ps
`include "palu_macros.svh"

module palu_shifter (
    input  palu_pkg::word_t a_i,
    input  logic [4:0]      shamt_i,
    input  palu_pkg::pw_t   pw_i,
    input  logic            left_i,
    input  logic            rotate_i,
    output palu_pkg::word_t res_o
);
    import palu_pkg::*;

    logic [4:0] lmask;
    logic [4:0] amt;

    assign lmask = lane_mask(pw_i);
    assign amt   = shamt_i & lmask;  // Amount modulo lane width

    // Each result bit fetches its source bit from the same lane
    always_comb begin
        logic [4:0] off;
        logic [4:0] base;
        logic [5:0] reach;
        logic       keep;
        for (int i = 0; i < `PALU_XLEN; i++) begin
            off  = 5'(i) & lmask;
            base = 5'(i) & ~lmask;
            if (left_i) begin
                keep  = off >= amt;
                reach = {1'b0, off} - {1'b0, amt};
            end else begin
                reach = {1'b0, off} + {1'b0, amt};
                keep  = reach <= {1'b0, lmask};
            end
            // Wrapped source bits only count for a rotate
            res_o[i] = (keep || rotate_i) ? a_i[base | (reach[4:0] & lmask)] : 1'b0;
        end
    end

endmodule

//--- hdl/palu_adder.sv
// --------------------
// Packed adder
// Lane-wise add or subtract, carries cut at lane edges
// --------------------
`timescale 1ns/100ps
`include "palu_macros.svh"

module palu_adder (
    input  palu_pkg::word_t a_i,
    input  palu_pkg::word_t b_i,
    input  palu_pkg::pw_t   pw_i,
    input  logic            sub_i,
    output palu_pkg::word_t sum_o
);
    import palu_pkg::*;

    logic [4:0] lmask;
    word_t      b_eff;

    assign lmask = lane_mask(pw_i);
    assign b_eff = sub_i ? ~b_i : b_i;  // Two's complement with carry-in below

    always_comb begin
        logic carry;
        carry = 1'b0;
        for (int i = 0; i < `PALU_XLEN; i++) begin
            // Fresh carry-in at each lane start
            if ((5'(i) & lmask) == 5'd0) carry = sub_i;
            sum_o[i] = a_i[i] ^ b_eff[i] ^ carry;
            carry    = (a_i[i] & b_eff[i]) | (carry & (a_i[i] ^ b_eff[i]));
        end
    end

endmodule

//--- hdl/palu_decode.sv
// --------------------
// Packed ALU decode
// Maps class and subclass onto a unit and operation flags
// --------------------
`timescale 1ns/100ps
`include "palu_macros.svh"

module palu_decode (
    input  logic                 valid_i,
    input  palu_pkg::iclass_t    iclass_i,
    input  palu_pkg::sclass_t    sclass_i,
    input  palu_pkg::pw_t        pw_i,
    input  palu_pkg::word_t      imm_i,
    input  palu_pkg::word_t      rs2_i,
    input  logic                 mul_busy_i,
    output palu_pkg::palu_ctrl_t ctrl_o,
    output logic                 mul_start_o
);
    import palu_pkg::*;

    logic shift_imm;

    always_comb begin
        ctrl_o     = '0;
        ctrl_o.pw  = pw_i;
        ctrl_o.imm = imm_i;
        shift_imm  = 1'b0;
        case (iclass_i)
            `PALU_CLASS_MOVE: begin
                ctrl_o.unit = MOVE;
                case (sclass_i)
                    `PALU_SC_CMOV_T:  ctrl_o.bop = CMOV_T;
                    `PALU_SC_CMOV_F:  ctrl_o.bop = CMOV_F;
                    `PALU_SC_GPR2XCR: ctrl_o.bop = GPR2XCR;
                    default:          ctrl_o.unit = NONE;
                endcase
            end
            `PALU_CLASS_BITWISE: begin
                ctrl_o.unit = BITWISE;
                case (sclass_i)
                    `PALU_SC_BOP:    ctrl_o.bop = BOP;
                    `PALU_SC_EXT:    ctrl_o.bop = EXT;
                    `PALU_SC_INS:    ctrl_o.bop = INS;
                    `PALU_SC_MIX_L:  ctrl_o.bop = MIX_L;
                    `PALU_SC_MIX_H:  ctrl_o.bop = MIX_H;
                    `PALU_SC_LD_LIU: ctrl_o.bop = LD_LIU;
                    `PALU_SC_LD_HIU: ctrl_o.bop = LD_HIU;
                    default:         ctrl_o.unit = NONE;
                endcase
            end
            `PALU_CLASS_ARITH: begin
                // Pick the unit from the subclass group
                case (sclass_i)
                    `PALU_SC_PADD, `PALU_SC_PSUB: ctrl_o.unit = ADD;
                    `PALU_SC_PMUL_L, `PALU_SC_PMUL_H,
                    `PALU_SC_PCLMUL_L, `PALU_SC_PCLMUL_H: ctrl_o.unit = MUL;
                    `PALU_SC_PSLL, `PALU_SC_PSRL, `PALU_SC_PROT,
                    `PALU_SC_PSLL_I, `PALU_SC_PSRL_I, `PALU_SC_PROT_I: ctrl_o.unit = SHIFT;
                    default: ctrl_o.unit = NONE;
                endcase
                ctrl_o.sub        = sclass_i == `PALU_SC_PSUB;
                ctrl_o.mul_high   = sclass_i == `PALU_SC_PMUL_H || sclass_i == `PALU_SC_PCLMUL_H;
                ctrl_o.carryless  = sclass_i == `PALU_SC_PCLMUL_L || sclass_i == `PALU_SC_PCLMUL_H;
                ctrl_o.shift_left = sclass_i == `PALU_SC_PSLL || sclass_i == `PALU_SC_PSLL_I;
                ctrl_o.rotate     = sclass_i == `PALU_SC_PROT || sclass_i == `PALU_SC_PROT_I;
                shift_imm         = sclass_i == `PALU_SC_PSLL_I || sclass_i == `PALU_SC_PSRL_I ||
                                    sclass_i == `PALU_SC_PROT_I;
            end
            default: ctrl_o.unit = NONE;  // Twiddle and reserved classes
        endcase
        ctrl_o.shamt = shift_imm ? imm_i[4:0] : rs2_i[4:0];
        if (!valid_i) ctrl_o.unit = NONE;
    end

    // Start only from an idle multiplier so a finished product is not rerun
    assign mul_start_o = (ctrl_o.unit == MUL) && !mul_busy_i;

endmodule

//--- hdl/palu_pkg.sv
// --------------------
// Packed ALU types
// Field vectors, unit and operation enums, decoded control
// --------------------
`include "palu_macros.svh"

package palu_pkg;

    typedef logic [`PALU_XLEN-1:0]   word_t;
    typedef logic [`PALU_XLEN/8-1:0] ben_t;
    typedef logic [2:0]              pw_t;
    typedef logic [3:0]              iclass_t;
    typedef logic [4:0]              sclass_t;

    // Which execute unit owns the instruction
    typedef enum logic [2:0] {
        NONE, MOVE, BITWISE, ADD, SHIFT, MUL
    } palu_unit_t;

    // Move and bitwise operations
    typedef enum logic [3:0] {
        CMOV_T, CMOV_F, GPR2XCR, BOP, EXT, INS, MIX_L, MIX_H, LD_LIU, LD_HIU
    } palu_bop_t;

    typedef struct packed {
        palu_unit_t unit;
        palu_bop_t  bop;
        pw_t        pw;
        logic       sub;
        logic       shift_left;
        logic       rotate;
        logic [4:0] shamt;      // Immediate or rs2, picked in decode
        logic       mul_high;
        logic       carryless;
        word_t      imm;
    } palu_ctrl_t;

    // Lane width minus one, doubles as the in-lane bit index mask
    function automatic logic [4:0] lane_mask(pw_t pw);
        case (pw)
            `PALU_PW_16: return 5'd15;
            `PALU_PW_8:  return 5'd7;
            `PALU_PW_4:  return 5'd3;
            `PALU_PW_2:  return 5'd1;
            default:     return 5'd31;
        endcase
    endfunction

endpackage

//--- palu_macros.svh
// --------------------
// Packed ALU encodings
// Word width, class, subclass and pack width codes
// --------------------
`ifndef PALU_MACROS_SVH
`define PALU_MACROS_SVH

`define PALU_XLEN 32

// Instruction classes
`define PALU_CLASS_MOVE    4'd1
`define PALU_CLASS_BITWISE 4'd2
`define PALU_CLASS_ARITH   4'd3

// Move subclasses
`define PALU_SC_CMOV_T   5'd0
`define PALU_SC_CMOV_F   5'd1
`define PALU_SC_GPR2XCR  5'd2

// Bitwise subclasses
`define PALU_SC_BOP      5'd0
`define PALU_SC_EXT      5'd1
`define PALU_SC_INS      5'd2
`define PALU_SC_MIX_L    5'd3
`define PALU_SC_MIX_H    5'd4
`define PALU_SC_LD_LIU   5'd5
`define PALU_SC_LD_HIU   5'd6

// Packed arithmetic subclasses
`define PALU_SC_PADD     5'd0
`define PALU_SC_PSUB     5'd1
`define PALU_SC_PMUL_L   5'd2
`define PALU_SC_PMUL_H   5'd3
`define PALU_SC_PCLMUL_L 5'd4
`define PALU_SC_PCLMUL_H 5'd5
`define PALU_SC_PSLL     5'd6
`define PALU_SC_PSRL     5'd7
`define PALU_SC_PROT     5'd8
`define PALU_SC_PSLL_I   5'd9
`define PALU_SC_PSRL_I   5'd10
`define PALU_SC_PROT_I   5'd11

// Pack width, named by lane size in bits
`define PALU_PW_32 3'd0
`define PALU_PW_16 3'd1
`define PALU_PW_8  3'd2
`define PALU_PW_4  3'd3
`define PALU_PW_2  3'd4

`endif
